/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f csr_uart.f --top-module csr_uart_tb

run: compile
	./obj_dir/Vcsr_uart_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log

/* csr_bus_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_bus_regs #(
  parameter int FIFO_DEPTH = 8
) (
  input  wire                                 CLK_I,
  input  wire                                 RST_I,
  input  wire  [csr_uart_pkg::bus_width-1:0]  ADR_I,
  input  wire  [csr_uart_pkg::bus_width-1:0]  DAT_I,
  input  wire                                 CYC_I,
  input  wire                                 STB_I,
  input  wire                                 WE_I,
  // byte lanes are ignored, every register is one byte wide
  input  wire  [3:0]                          SEL_I,
  output logic [csr_uart_pkg::bus_width-1:0]  DAT_O,
  output logic                                ACK_O,
  output logic [csr_uart_pkg::byte_width-1:0] leds,
  output logic                                uart_interrupt,
  uart_fifo_if.producer                       fifo
);

  localparam int lw = $clog2(FIFO_DEPTH + 1);
  localparam int bw = csr_uart_pkg::byte_width;

  logic          ack_q;
  logic [bw-1:0] rd_q;
  logic [bw-1:0] reset_q;
  logic [bw-1:0] scratch_q;
  logic [bw-1:0] bus_errors_q;
  logic [bw-1:0] leds_q;
  logic [bw-1:0] irq_en_q;
  logic          irq_q;

  logic          req;
  logic          wr;
  logic [10:0]   ofs;
  logic          sel_ctrl;
  logic          sel_uart;
  logic          sel_leds;
  logic          hit;
  logic [bw-1:0] rd_byte;
  logic          fifo_full;
  logic          fifo_empty;
  logic [3:0]    level_field;
  logic          wr_reset;
  logic          wr_scratch;
  logic          wr_leds;
  logic          wr_irq_en;
  logic          wr_txdata;
  logic          bus_err;

  // new access only while no ack is pending
  assign req = CYC_I & STB_I & ~ACK_O;
  assign wr  = req & WE_I;
  assign ofs = ADR_I[10:0];

  assign sel_ctrl = ADR_I[31:11] == csr_uart_pkg::ctrl_base[31:11];
  assign sel_uart = ADR_I[31:11] == csr_uart_pkg::uart_base[31:11];
  assign sel_leds = ADR_I[31:11] == csr_uart_pkg::leds_base[31:11];

  assign fifo_full   = fifo.level == lw'(FIFO_DEPTH);
  assign fifo_empty  = fifo.level == '0;
  assign level_field = 4'(fifo.level);

  // offset decode and read mux
  always_comb begin
    hit     = 1'b0;
    rd_byte = '0;
    if (sel_ctrl) begin
      case (ofs)
        csr_uart_pkg::ctrl_reset_ofs: begin
          hit     = 1'b1;
          rd_byte = reset_q;
        end
        csr_uart_pkg::ctrl_scratch_ofs: begin
          hit     = 1'b1;
          rd_byte = scratch_q;
        end
        csr_uart_pkg::ctrl_bus_errors_ofs: begin
          hit     = 1'b1;
          rd_byte = bus_errors_q;
        end
        default: ;
      endcase
    end else if (sel_uart) begin
      case (ofs)
        // txdata is write only and reads 0
        csr_uart_pkg::uart_txdata_ofs: hit = 1'b1;
        csr_uart_pkg::uart_status_ofs: begin
          hit     = 1'b1;
          rd_byte = {level_field, 2'b00, fifo_empty, fifo_full};
        end
        csr_uart_pkg::uart_irq_en_ofs: begin
          hit     = 1'b1;
          rd_byte = irq_en_q;
        end
        default: ;
      endcase
    end else if (sel_leds) begin
      if (ofs == csr_uart_pkg::leds_out_ofs) begin
        hit     = 1'b1;
        rd_byte = leds_q;
      end
    end
  end

  assign wr_reset   = wr & sel_ctrl & (ofs == csr_uart_pkg::ctrl_reset_ofs);
  assign wr_scratch = wr & sel_ctrl & (ofs == csr_uart_pkg::ctrl_scratch_ofs);
  assign wr_leds    = wr & sel_leds & (ofs == csr_uart_pkg::leds_out_ofs);
  assign wr_irq_en  = wr & sel_uart & (ofs == csr_uart_pkg::uart_irq_en_ofs);
  assign wr_txdata  = wr & sel_uart & (ofs == csr_uart_pkg::uart_txdata_ofs);

  // unmapped access, or a byte dropped on a full fifo
  assign bus_err = req & (~hit | (wr_txdata & fifo_full));

  assign fifo.wr_data = DAT_I[bw-1:0];
  assign fifo.push    = wr_txdata & ~fifo_full;
  assign fifo.flush   = wr_reset & DAT_I[0];

  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      ack_q        <= 1'b0;
      reset_q      <= '0;
      scratch_q    <= '0;
      bus_errors_q <= '0;
      leds_q       <= '0;
      irq_en_q     <= '0;
      irq_q        <= 1'b0;
    end else begin
      ack_q <= req;
      irq_q <= irq_en_q[0] & fifo_empty;
      if (wr_reset) begin
        reset_q <= DAT_I[bw-1:0];
      end
      if (wr_scratch) begin
        scratch_q <= DAT_I[bw-1:0];
      end
      if (wr_leds) begin
        leds_q <= DAT_I[bw-1:0];
      end
      if (wr_irq_en) begin
        irq_en_q <= DAT_I[bw-1:0];
      end
      // wraps at 8 bits
      if (bus_err) begin
        bus_errors_q <= bus_errors_q + 1'b1;
      end
    end
  end

  // read data held for the ack cycle
  always_ff @(posedge CLK_I) begin
    if (req) begin
      rd_q <= rd_byte;
    end
  end

  assign ACK_O = ack_q;
  assign DAT_O = ack_q ? {{(csr_uart_pkg::bus_width - bw){1'b0}}, rd_q} : '0;
  assign leds  = leds_q;
  assign uart_interrupt = irq_q;

endmodule

`default_nettype wire

/* csr_uart.f */
csr_uart_pkg.sv
uart_fifo_if.sv
csr_bus_regs.sv
uart_tx_fifo.sv
uart_tx_serializer.sv
csr_uart_top.sv
csr_uart_sva.sv
csr_uart_tb.sv

/* csr_uart_pkg.sv */
`default_nettype none

package csr_uart_pkg;

  // bus and character widths
  localparam int bus_width  = 32;
  localparam int byte_width = 8;

  // region bases, a region matches on address bits 31 to 11
  localparam logic [bus_width-1:0] ctrl_base = 32'hf000_0000;
  localparam logic [bus_width-1:0] uart_base = 32'hf000_1000;
  localparam logic [bus_width-1:0] leds_base = 32'hf000_3800;

  // control region offsets
  localparam logic [10:0] ctrl_reset_ofs      = 11'h000;
  localparam logic [10:0] ctrl_scratch_ofs    = 11'h004;
  localparam logic [10:0] ctrl_bus_errors_ofs = 11'h008;

  // uart region offsets
  localparam logic [10:0] uart_txdata_ofs = 11'h000;
  localparam logic [10:0] uart_status_ofs = 11'h004;
  localparam logic [10:0] uart_irq_en_ofs = 11'h008;

  // led region
  localparam logic [10:0] leds_out_ofs = 11'h000;

endpackage

`default_nettype wire

/* csr_uart_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_uart_sva (
  input wire CLK_I,
  input wire RST_I,
  input wire CYC_I,
  input wire STB_I,
  input wire ACK_O,
  input wire txd,
  input wire pop,
  input wire empty
);

  logic popped;

  // set by the first pop after reset
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      popped <= 1'b0;
    end else if (pop) begin
      popped <= 1'b1;
    end
  end

  ack_one_cycle: assert property (@(posedge CLK_I) disable iff (RST_I) ACK_O |=> !ACK_O)
    else $error("ACK_O high on two consecutive cycles");

  ack_after_req: assert property (@(posedge CLK_I) disable iff (RST_I)
    $rose(ACK_O) |-> $past(CYC_I && STB_I))
    else $error("ACK_O rose without a request in the cycle before");

  txd_idle: assert property (@(posedge CLK_I) disable iff (RST_I) !popped |-> txd)
    else $error("txd left idle before the first pop");

  // a pop takes a real byte and the start bit follows on the next edge
  pop_starts_frame: assert property (@(posedge CLK_I) disable iff (RST_I)
    pop |-> !empty ##1 !txd)
    else $error("pop issued while the FIFO is empty or no start bit followed");

endmodule

bind csr_uart_top csr_uart_sva csr_uart_sva_inst (
  .CLK_I (CLK_I),
  .RST_I (RST_I),
  .CYC_I (CYC_I),
  .STB_I (STB_I),
  .ACK_O (ACK_O),
  .txd   (txd),
  .pop   (pop),
  .empty (empty)
);

`default_nettype wire

/* csr_uart_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_uart_tb;

  localparam int FIFO_DEPTH   = 8;
  localparam int CLKS_PER_BIT = 16;

  localparam logic [31:0] reset_adr =
    csr_uart_pkg::ctrl_base | 32'(csr_uart_pkg::ctrl_reset_ofs);
  localparam logic [31:0] scratch_adr =
    csr_uart_pkg::ctrl_base | 32'(csr_uart_pkg::ctrl_scratch_ofs);
  localparam logic [31:0] errors_adr =
    csr_uart_pkg::ctrl_base | 32'(csr_uart_pkg::ctrl_bus_errors_ofs);
  localparam logic [31:0] txdata_adr =
    csr_uart_pkg::uart_base | 32'(csr_uart_pkg::uart_txdata_ofs);
  localparam logic [31:0] status_adr =
    csr_uart_pkg::uart_base | 32'(csr_uart_pkg::uart_status_ofs);
  localparam logic [31:0] irq_en_adr =
    csr_uart_pkg::uart_base | 32'(csr_uart_pkg::uart_irq_en_ofs);
  localparam logic [31:0] leds_adr =
    csr_uart_pkg::leds_base | 32'(csr_uart_pkg::leds_out_ofs);

  logic        CLK_I;
  logic        RST_I;
  logic [31:0] ADR_I;
  logic [31:0] DAT_I;
  logic        CYC_I;
  logic        STB_I;
  logic        WE_I;
  logic [3:0]  SEL_I;
  logic [31:0] DAT_O;
  logic        ACK_O;
  logic        txd;
  logic        uart_interrupt;
  logic [7:0]  leds;

  int          errors;
  int          tests_ok;
  int          tests_bad;
  int          start;
  int          frames;
  logic        got;
  logic [31:0] d;
  logic [31:0] r;
  logic [7:0]  e0;
  logic [7:0]  e1;
  logic [7:0]  tx_q[$];
  logic [7:0]  rx_q[$];

  csr_uart_top #(
    .FIFO_DEPTH   (FIFO_DEPTH),
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) csr_uart_top_inst (
    .CLK_I          (CLK_I),
    .RST_I          (RST_I),
    .ADR_I          (ADR_I),
    .DAT_I          (DAT_I),
    .CYC_I          (CYC_I),
    .STB_I          (STB_I),
    .WE_I           (WE_I),
    .SEL_I          (SEL_I),
    .DAT_O          (DAT_O),
    .ACK_O          (ACK_O),
    .txd            (txd),
    .uart_interrupt (uart_interrupt),
    .leds           (leds)
  );

  always #50 CLK_I = ~CLK_I;

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("** Error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    assert (ok === 1'b1) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  // one classic cycle, outputs sampled on the falling edge
  task automatic bus_cycle(input logic we, input logic [31:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int n;
    n = 0;
    @(posedge CLK_I);
    ADR_I <= adr;
    DAT_I <= wdat;
    WE_I  <= we;
    CYC_I <= 1'b1;
    STB_I <= 1'b1;
    do begin
      @(negedge CLK_I);
      n++;
    end while (ACK_O !== 1'b1 && n < 20);
    check_true(ACK_O, $sformatf("no ack within 20 cycles for address 0x%08h", adr));
    rdat = DAT_O;
    @(posedge CLK_I);
    CYC_I <= 1'b0;
    STB_I <= 1'b0;
    WE_I  <= 1'b0;
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] wdat);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, wdat, unused);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] rdat);
    bus_cycle(1'b0, adr, 32'h0, rdat);
  endtask

  // 8N1 decoder, samples each bit in its middle
  task automatic receive_frame(output logic seen);
    int n;
    logic [7:0] data;
    n = 0;
    seen = 1'b0;
    do begin
      @(negedge CLK_I);
      n++;
    end while (txd !== 1'b0 && n < 20 * CLKS_PER_BIT);
    if (txd === 1'b0) begin
      seen = 1'b1;
      repeat (CLKS_PER_BIT / 2) @(negedge CLK_I);
      check_true(txd === 1'b0, "start bit on txd ended early");
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge CLK_I);
        data[i] = txd;
      end
      repeat (CLKS_PER_BIT) @(negedge CLK_I);
      check_true(txd === 1'b1, "stop bit on txd was low");
      rx_q.push_back(data);
    end
  endtask

  // collect frames until the line stays quiet
  task automatic receive_all(output int count);
    logic seen;
    count = 0;
    do begin
      receive_frame(seen);
      if (seen) begin
        count++;
      end
    end while (seen && count < 64);
  endtask

  task automatic wait_irq(input logic level, input int limit);
    int n;
    n = 0;
    do begin
      @(negedge CLK_I);
      n++;
    end while (uart_interrupt !== level && n < limit);
    check_true(uart_interrupt === level,
               $sformatf("uart_interrupt did not reach %0b within %0d cycles", level, limit));
  endtask

  task automatic finish_test(input string name, input int first_error);
    if (errors == first_error) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - first_error);
    end
  endtask

  initial begin
    CLK_I  = 1'b0;
    RST_I  = 1'b1;
    ADR_I  = '0;
    DAT_I  = '0;
    CYC_I  = 1'b0;
    STB_I  = 1'b0;
    WE_I   = 1'b0;
    SEL_I  = 4'hf;
    errors = 0;
    tests_ok  = 0;
    tests_bad = 0;
    void'($urandom(86));
    repeat (5) @(posedge CLK_I);
    RST_I <= 1'b0;

    start = errors;
    @(negedge CLK_I);
    check_value("txd idle", 32'h1, 32'(txd));
    check_value("ack idle", 32'h0, 32'(ACK_O));
    check_value("leds port", 32'h0, 32'(leds));
    check_value("irq idle", 32'h0, 32'(uart_interrupt));
    wb_read(reset_adr, r);
    check_value("reset reg", 32'h0, r);
    wb_read(scratch_adr, r);
    check_value("scratch reg", 32'h0, r);
    wb_read(errors_adr, r);
    check_value("bus_errors reg", 32'h0, r);
    wb_read(irq_en_adr, r);
    check_value("irq_en reg", 32'h0, r);
    wb_read(status_adr, r);
    check_value("status reg", 32'h2, r);
    finish_test("after_reset", start);

    start = errors;
    d = $urandom;
    wb_write(scratch_adr, d);
    wb_read(scratch_adr, r);
    check_value("scratch readback", 32'(d[7:0]), r);
    d = $urandom;
    wb_write(leds_adr, d);
    @(negedge CLK_I);
    check_value("leds port", 32'(d[7:0]), 32'(leds));
    wb_read(leds_adr, r);
    check_value("leds readback", 32'(d[7:0]), r);
    finish_test("scratch_leds", start);

    start = errors;
    // no bus error has happened since reset
    e0 = 8'd0;
    wb_read(32'h1234_5678, r);
    check_value("unmapped read", 32'h0, r);
    wb_read(errors_adr, r);
    check_value("bus_errors +1", 32'(8'(e0 + 8'd1)), r);
    wb_write(32'hf000_000c, $urandom);
    wb_read(errors_adr, r);
    check_value("bus_errors +2", 32'(8'(e0 + 8'd2)), r);
    wb_read(32'hf000_1010, r);
    check_value("unused offset read", 32'h0, r);
    wb_read(errors_adr, r);
    check_value("bus_errors +3", 32'(8'(e0 + 8'd3)), r);
    finish_test("unmapped", start);

    start = errors;
    tx_q.delete();
    rx_q.delete();
    repeat (5) tx_q.push_back(8'($urandom));
    fork
      foreach (tx_q[i]) wb_write(txdata_adr, 32'(tx_q[i]));
      for (int i = 0; i < 5; i++) begin
        receive_frame(got);
        check_true(got, "no frame started on txd");
      end
    join
    foreach (tx_q[i]) check_value("uart byte", 32'(tx_q[i]), 32'(rx_q[i]));
    finish_test("uart_tx", start);

    start = errors;
    // the three counted accesses of the unmapped test
    e0 = 8'd3;
    tx_q.delete();
    rx_q.delete();
    repeat (FIFO_DEPTH + 3) tx_q.push_back(8'($urandom));
    fork
      foreach (tx_q[i]) wb_write(txdata_adr, 32'(tx_q[i]));
      receive_all(frames);
    join
    wb_read(errors_adr, r);
    e1 = r[7:0];
    check_value("frames plus drops", 32'(FIFO_DEPTH + 3), 32'(frames + int'(8'(e1 - e0))));
    foreach (rx_q[i]) check_value("overflow order", 32'(tx_q[i]), 32'(rx_q[i]));
    finish_test("overflow", start);

    start = errors;
    wb_write(irq_en_adr, 32'h1);
    wait_irq(1'b1, 4);
    tx_q.delete();
    rx_q.delete();
    repeat (2) tx_q.push_back(8'($urandom));
    fork
      begin
        wb_write(txdata_adr, 32'(tx_q[0]));
        wb_write(txdata_adr, 32'(tx_q[1]));
        wait_irq(1'b0, 4);
        wait_irq(1'b1, 30 * CLKS_PER_BIT);
      end
      for (int i = 0; i < 2; i++) begin
        receive_frame(got);
        check_true(got, "no frame started on txd");
      end
    join
    foreach (tx_q[i]) check_value("irq frame", 32'(tx_q[i]), 32'(rx_q[i]));
    // queue four bytes, then flush while the first is on the line
    tx_q.delete();
    rx_q.delete();
    repeat (4) tx_q.push_back(8'($urandom));
    fork
      begin
        foreach (tx_q[i]) wb_write(txdata_adr, 32'(tx_q[i]));
        wb_write(reset_adr, 32'h1);
        wb_read(status_adr, r);
        check_value("status after flush", 32'h2, r);
      end
      receive_all(frames);
    join
    check_value("frames after flush", 32'h1, 32'(frames));
    check_value("frame before flush", 32'(tx_q[0]), 32'(rx_q[0]));
    finish_test("irq_flush", start);

    $display("tests done: %0d passed, %0d failed, %0d errors", tests_ok, tests_bad, errors);
    if (tests_bad == 0 && errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* csr_uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_uart_top #(
  parameter int FIFO_DEPTH   = 8,
  parameter int CLKS_PER_BIT = 16
) (
  input  wire                                 CLK_I,
  input  wire                                 RST_I,
  input  wire  [csr_uart_pkg::bus_width-1:0]  ADR_I,
  input  wire  [csr_uart_pkg::bus_width-1:0]  DAT_I,
  input  wire                                 CYC_I,
  input  wire                                 STB_I,
  input  wire                                 WE_I,
  input  wire  [3:0]                          SEL_I,
  output logic [csr_uart_pkg::bus_width-1:0]  DAT_O,
  output logic                                ACK_O,
  output logic                                txd,
  output logic                                uart_interrupt,
  output logic [csr_uart_pkg::byte_width-1:0] leds
);

  logic [csr_uart_pkg::byte_width-1:0] rd_data;
  logic                                empty;
  logic                                pop;

  // register block to fifo write side
  uart_fifo_if #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_bus ();

  csr_bus_regs #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) csr_bus_regs_inst (
    .CLK_I          (CLK_I),
    .RST_I          (RST_I),
    .ADR_I          (ADR_I),
    .DAT_I          (DAT_I),
    .CYC_I          (CYC_I),
    .STB_I          (STB_I),
    .WE_I           (WE_I),
    .SEL_I          (SEL_I),
    .DAT_O          (DAT_O),
    .ACK_O          (ACK_O),
    .leds           (leds),
    .uart_interrupt (uart_interrupt),
    .fifo           (fifo_bus.producer)
  );

  uart_tx_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) uart_tx_fifo_inst (
    .CLK_I   (CLK_I),
    .RST_I   (RST_I),
    .pop     (pop),
    .fifo    (fifo_bus.buffer),
    .rd_data (rd_data),
    .empty   (empty)
  );

  uart_tx_serializer #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) uart_tx_serializer_inst (
    .CLK_I   (CLK_I),
    .RST_I   (RST_I),
    .rd_data (rd_data),
    .empty   (empty),
    .pop     (pop),
    .txd     (txd)
  );

endmodule

`default_nettype wire

/* uart_fifo_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface uart_fifo_if #(
  parameter int FIFO_DEPTH = 8
);

  logic [csr_uart_pkg::byte_width-1:0] wr_data;
  logic                                push;
  logic                                flush;
  // fill count, 0 up to FIFO_DEPTH
  logic [$clog2(FIFO_DEPTH + 1)-1:0]   level;

  // register block side
  modport producer (
    output wr_data,
    output push,
    output flush,
    input  level
  );

  // fifo storage side
  modport buffer (
    input  wr_data,
    input  push,
    input  flush,
    output level
  );

endinterface

`default_nettype wire

/* uart_tx_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  wire                                 CLK_I,
  input  wire                                 RST_I,
  input  wire                                 pop,
  uart_fifo_if.buffer                         fifo,
  output logic [csr_uart_pkg::byte_width-1:0] rd_data,
  output logic                                empty
);

  localparam int aw = $clog2(FIFO_DEPTH);
  localparam int lw = $clog2(FIFO_DEPTH + 1);

  logic [csr_uart_pkg::byte_width-1:0] mem [FIFO_DEPTH];
  logic [aw-1:0]                       wr_ptr;
  logic [aw-1:0]                       rd_ptr;
  logic [lw-1:0]                       count;
  logic                                do_push;
  logic                                do_pop;

  // a push on a full fifo is refused here as well
  assign do_push = fifo.push & (count != lw'(FIFO_DEPTH));
  assign do_pop  = pop & ~empty;

  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (fifo.flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // pointers wrap since depth is a power of two
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK_I) begin
    if (do_push && !fifo.flush) begin
      mem[wr_ptr] <= fifo.wr_data;
    end
  end

  // head of queue shows without a read cycle
  assign rd_data    = mem[rd_ptr];
  assign empty      = count == '0;
  assign fifo.level = count;

endmodule

`default_nettype wire

/* uart_tx_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_serializer #(
  parameter int CLKS_PER_BIT = 16
) (
  input  wire                                CLK_I,
  input  wire                                RST_I,
  input  wire [csr_uart_pkg::byte_width-1:0] rd_data,
  input  wire                                empty,
  output logic                               pop,
  output logic                               txd
);

  localparam int cw = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  // start bit, eight data bits, stop bit
  localparam int frame_bits = csr_uart_pkg::byte_width + 2;

  logic                  busy;
  logic [cw-1:0]         clk_cnt;
  logic [3:0]            bit_cnt;
  logic [frame_bits-1:0] shreg;
  logic                  bit_done;

  assign bit_done = clk_cnt == cw'(CLKS_PER_BIT - 1);

  // take the head as soon as the line is free
  assign pop = ~busy & ~empty;

  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
      // all ones keeps the line at mark
      shreg   <= '1;
    end else if (pop) begin
      busy    <= 1'b1;
      clk_cnt <= '0;
      bit_cnt <= '0;
      shreg   <= {1'b1, rd_data, 1'b0};
    end else if (busy) begin
      if (bit_done) begin
        clk_cnt <= '0;
        // shift in ones so the line idles high
        shreg   <= {1'b1, shreg[frame_bits-1:1]};
        if (bit_cnt == 4'(frame_bits - 1)) begin
          busy <= 1'b0;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  assign txd = shreg[0];

endmodule

`default_nettype wire
